/* list.f */
rtl/dds_pkg.sv
rtl/cfg_regs.sv
rtl/wave_gen.sv
rtl/lfsr_gen.sv
rtl/modulator.sv
rtl/key_hold_tracker.sv
rtl/dds_lab_top.sv
tests/dds_lab_checker.sv
tests/tb_dds_lab.sv

/* rtl/cfg_regs.sv */
`timescale 1ns/100ps

module cfg_regs (
   input  logic               CLK_25MHZ,
   input  logic               reset_from_key,
   input  logic               cfg_req,
   input  dds_pkg::cfg_cmd_t  cfg_cmd,
   output logic               cfg_ack,
   output dds_pkg::dds_ctrl_t dds_ctrl
);
   import dds_pkg::*;

   logic new_req;

   // req high with ack still low starts a write
   assign new_req = cfg_req & ~cfg_ack;

   //////////////////////////////////////////////////////////////////////
   // four-phase responder
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         cfg_ack  <= 1'b0;
         dds_ctrl <= '0;
      end
      else
      begin
         if (new_req)
         begin
            cfg_ack <= 1'b1;  // value lands on the same edge
            case (cfg_cmd.addr)
               CFG_PHASE_INC:
               begin
                  dds_ctrl.phase_inc <= cfg_cmd.word.freq;
               end
               CFG_SELECT:
               begin
                  dds_ctrl.wave_sel <= cfg_cmd.word.sel.wave_sel;
                  dds_ctrl.mod_sel  <= cfg_cmd.word.sel.mod_sel;
               end
            endcase
         end
         else if (!cfg_req)
         begin
            cfg_ack <= 1'b0;  // host let go, close the cycle
         end
      end
   end

endmodule

/* rtl/dds_lab_top.sv */
`timescale 1ns/100ps

module dds_lab_top (
   input  logic                       CLK_25MHZ,
   input  logic                       reset_from_key,
   input  logic                       cfg_req,
   input  dds_pkg::cfg_cmd_t          cfg_cmd,
   input  dds_pkg::kbd_event_t        kbd_event,
   output logic                       cfg_ack,
   output dds_pkg::sample_t           sig_out,
   output dds_pkg::sample_t           mod_out,
   output logic [dds_pkg::num_keys-1:0] held_keys
);
   import dds_pkg::*;

   dds_ctrl_t dds_ctrl;
   sample_t   sin_wave;
   sample_t   cos_wave;
   sample_t   saw_wave;
   sample_t   squ_wave;
   logic      lfsr_bit;

   // host side register block
   cfg_regs u_cfg_regs (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .cfg_req        (cfg_req),
      .cfg_cmd        (cfg_cmd),
      .cfg_ack        (cfg_ack),
      .dds_ctrl       (dds_ctrl)
   );

   wave_gen u_wave_gen (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .phase_inc      (dds_ctrl.phase_inc),
      .sin_out        (sin_wave),
      .cos_out        (cos_wave),
      .saw_out        (saw_wave),
      .squ_out        (squ_wave)
   );

   lfsr_gen u_lfsr_gen (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .lfsr_bit       (lfsr_bit)
   );

   modulator u_modulator (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .sin_in         (sin_wave),
      .cos_in         (cos_wave),
      .saw_in         (saw_wave),
      .squ_in         (squ_wave),
      .lfsr_bit       (lfsr_bit),
      .wave_sel       (dds_ctrl.wave_sel),
      .mod_sel        (dds_ctrl.mod_sel),
      .sig_out        (sig_out),
      .mod_out        (mod_out)
   );

   key_hold_tracker u_key_hold_tracker (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .kbd_event      (kbd_event),
      .held_keys      (held_keys)
   );

endmodule

/* rtl/dds_pkg.sv */
package dds_pkg;

   //////////////////////////////////////////////////////////////////////
   // widths and constants
   //////////////////////////////////////////////////////////////////////

   localparam int phase_w          = 32;
   localparam int sample_w         = 12;
   localparam int table_aw         = 6;  // top phase bits into the sine rom
   localparam int table_depth      = 2 ** table_aw;
   localparam int lfsr_w           = 5;
   localparam int lfsr_tick_cycles = 50;  // short for sim, slow clock on the board
   localparam int lfsr_tick_w      = $clog2(lfsr_tick_cycles);
   localparam int num_keys         = 17;
   localparam int key_code_w       = 5;

   typedef logic signed [sample_w-1:0] sample_t;

   localparam logic [table_aw-1:0] cos_offset = 6'd16;  // quarter period
   localparam sample_t ask_level = 12'sd258;
   localparam sample_t lfsr_mark = 12'h800;
   localparam sample_t square_hi = 12'h7FF;
   localparam sample_t square_lo = 12'h801;
   localparam logic [lfsr_w-1:0] lfsr_seed = 5'b00001;
   localparam string sine_file = "rtl/sine_table.mem";

   //////////////////////////////////////////////////////////////////////
   // selectors and register map
   //////////////////////////////////////////////////////////////////////

   typedef enum logic [1:0] {SINE = 2'd0, COS = 2'd1, SAW = 2'd2, SQUARE = 2'd3} wave_sel_e;
   typedef enum logic [1:0] {ASK = 2'd0, BPSK = 2'd1, LFSR_SHOW = 2'd2, NONE = 2'd3} mod_sel_e;
   typedef enum logic {CFG_PHASE_INC = 1'b0, CFG_SELECT = 1'b1} cfg_addr_e;

   // select register layout
   typedef struct packed {
      logic [27:0] rsvd;
      mod_sel_e    mod_sel;
      wave_sel_e   wave_sel;
   } cfg_sel_t;

   // same data word, meaning depends on addr
   typedef union packed {
      logic [phase_w-1:0] freq;
      cfg_sel_t           sel;
   } cfg_word_u;

   typedef struct packed {
      cfg_addr_e addr;
      cfg_word_u word;
   } cfg_cmd_t;

   typedef struct packed {
      logic                  valid;
      logic                  brk;  // 1 = break, 0 = make
      logic [key_code_w-1:0] code;
   } kbd_event_t;

   typedef struct packed {
      logic [phase_w-1:0] phase_inc;
      wave_sel_e          wave_sel;
      mod_sel_e           mod_sel;
   } dds_ctrl_t;

endpackage

/* rtl/key_hold_tracker.sv */
`timescale 1ns/100ps

module key_hold_tracker (
   input  logic                         CLK_25MHZ,
   input  logic                         reset_from_key,
   input  dds_pkg::kbd_event_t          kbd_event,
   output logic [dds_pkg::num_keys-1:0] held_keys
);
   import dds_pkg::*;

   logic code_ok;

   // codes past the last tracked key are dropped
   assign code_ok = (kbd_event.code < key_code_w'(num_keys));

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         held_keys <= '0;
      end
      else if (kbd_event.valid && code_ok)
      begin
         held_keys[kbd_event.code] <= ~kbd_event.brk;  // make sets, break clears
      end
   end

endmodule

/* rtl/lfsr_gen.sv */
`timescale 1ns/100ps

module lfsr_gen (
   input  logic CLK_25MHZ,
   input  logic reset_from_key,
   output logic lfsr_bit
);
   import dds_pkg::*;

   logic [lfsr_tick_w-1:0] tick_cnt;
   logic                   tick;
   logic [lfsr_w-1:0]      lfsr_q;

   // stands in for the old slow clock
   assign tick = (tick_cnt == lfsr_tick_w'(lfsr_tick_cycles - 1));

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
         tick_cnt <= '0;
      else if (tick)
         tick_cnt <= '0;
      else
         tick_cnt <= tick_cnt + 1'b1;
   end

   // x^5 + x^3 + 1, 31 states
   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
         lfsr_q <= lfsr_seed;
      else if (tick)
         lfsr_q <= {lfsr_q[lfsr_w-2:0], lfsr_q[4] ^ lfsr_q[2]};
   end

   assign lfsr_bit = lfsr_q[0];

endmodule

/* rtl/modulator.sv */
`timescale 1ns/100ps

module modulator (
   input  logic               CLK_25MHZ,
   input  logic               reset_from_key,
   input  dds_pkg::sample_t   sin_in,
   input  dds_pkg::sample_t   cos_in,
   input  dds_pkg::sample_t   saw_in,
   input  dds_pkg::sample_t   squ_in,
   input  logic               lfsr_bit,
   input  dds_pkg::wave_sel_e wave_sel,
   input  dds_pkg::mod_sel_e  mod_sel,
   output dds_pkg::sample_t   sig_out,
   output dds_pkg::sample_t   mod_out
);
   import dds_pkg::*;

   sample_t sel_wave;
   sample_t mod_word;

   //////////////////////////////////////////////////////////////////////
   // wave and modulation select
   //////////////////////////////////////////////////////////////////////

   always_comb
   begin
      case (wave_sel)
         SINE:    sel_wave = sin_in;
         COS:     sel_wave = cos_in;
         SAW:     sel_wave = saw_in;
         default: sel_wave = squ_in;
      endcase
   end

   always_comb
   begin
      case (mod_sel)
         ASK:       mod_word = lfsr_bit ? ask_level : '0;
         BPSK:      mod_word = lfsr_bit ? -sel_wave : sel_wave;  // phase flip on 1
         LFSR_SHOW: mod_word = lfsr_bit ? lfsr_mark : '0;
         default:   mod_word = '0;
      endcase
   end

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         sig_out <= '0;
         mod_out <= '0;
      end
      else
      begin
         sig_out <= sel_wave;
         mod_out <= mod_word;
      end
   end

endmodule

/* rtl/sine_table.mem */
// one 12-bit two's complement sine sample per line, table index 0 to 63
000
0C9
18F
252
30F
3C5
471
513
5A7
62E
6A6
70D
763
7A7
7D8
7F5
7FF
7F5
7D8
7A7
763
70D
6A6
62E
5A7
513
471
3C5
30F
252
18F
0C9
000
F37
E71
DAE
CF1
C3B
B8F
AED
A59
9D2
95A
8F3
89D
859
828
80B
801
80B
828
859
89D
8F3
95A
9D2
A59
AED
B8F
C3B
CF1
DAE
E71
F37

/* rtl/wave_gen.sv */
`timescale 1ns/100ps

module wave_gen (
   input  logic                        CLK_25MHZ,
   input  logic                        reset_from_key,
   input  logic [dds_pkg::phase_w-1:0] phase_inc,
   output dds_pkg::sample_t            sin_out,
   output dds_pkg::sample_t            cos_out,
   output dds_pkg::sample_t            saw_out,
   output dds_pkg::sample_t            squ_out
);
   import dds_pkg::*;

   logic [phase_w-1:0]  phase_acc;
   logic [table_aw-1:0] sin_idx;
   logic [table_aw-1:0] cos_idx;
   sample_t             sine_rom [0:table_depth-1];  // one full period

   initial
   begin
      $readmemh(sine_file, sine_rom);
   end

   assign sin_idx = phase_acc[phase_w-1 -: table_aw];
   assign cos_idx = sin_idx + cos_offset;  // wraps mod 64

   //////////////////////////////////////////////////////////////////////
   // phase accumulator
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
         phase_acc <= '0;
      else
         phase_acc <= phase_acc + phase_inc;
   end

   // samples trail the accumulator by one clock
   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         sin_out <= '0;
         cos_out <= '0;
         saw_out <= '0;
         squ_out <= '0;
      end
      else
      begin
         sin_out <= sine_rom[sin_idx];
         cos_out <= sine_rom[cos_idx];
         saw_out <= phase_acc[phase_w-1 -: sample_w];  // top 12 bits as a ramp
         squ_out <= phase_acc[phase_w-1] ? square_lo : square_hi;
      end
   end

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the dds lab testbench with verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_dds_lab -f list.f -o tb_dds_lab
./obj_dir/tb_dds_lab | tee sim.log
if grep -q "^TEST PASSED$" sim.log
then
   echo "simulation passed"
else
   echo "simulation failed"
   exit 1
fi

/* tests/dds_lab_checker.sv */
`timescale 1ns/100ps

module dds_lab_checker (
   input logic              CLK_25MHZ,
   input logic              reset_from_key,
   input logic              cfg_req,
   input logic              cfg_ack,
   input dds_pkg::mod_sel_e mod_sel,
   input dds_pkg::sample_t  mod_out
);
   import dds_pkg::*;

   //////////////////////////////////////////////////////////////////////
   // four-phase handshake rules
   //////////////////////////////////////////////////////////////////////

   ack_rise_needs_req: assert property (@(posedge CLK_25MHZ) disable iff (reset_from_key)
      $rose(cfg_ack) |-> $past(cfg_req))
      else $error("cfg_ack rose while cfg_req was low");

   // ack held as long as the host keeps req up
   ack_held_with_req: assert property (@(posedge CLK_25MHZ) disable iff (reset_from_key)
      (cfg_ack && cfg_req) |=> cfg_ack)
      else $error("cfg_ack dropped before cfg_req fell");

   // mod_out trails mod_sel by one register stage
   ask_two_levels: assert property (@(posedge CLK_25MHZ) disable iff (reset_from_key)
      ($past(mod_sel) == ASK) |-> (mod_out == '0 || mod_out == ask_level))
      else $error("mod_out in ASK mode is neither zero nor the ASK level");

endmodule

/* tests/tb_dds_lab.sv */
`timescale 1ns/100ps

module tb_dds_lab;
   import dds_pkg::*;

   localparam int clk_half    = 20;
   localparam int drive_dly   = 1;
   localparam int num_writes  = 16;
   localparam int wave_cycles = 80;
   localparam int mod_cycles  = 21 * lfsr_tick_cycles;  // a bit over 20 ticks
   localparam int num_events  = 120;
   localparam int wd_cycles   = 3 + (num_writes + 12) * 8 + 4 * wave_cycles
                                + 4 * mod_cycles + num_events + 100;

   logic                CLK_25MHZ;
   logic                reset_from_key;
   logic                cfg_req;
   cfg_cmd_t            cfg_cmd;
   kbd_event_t          kbd_event;
   logic                cfg_ack;
   sample_t             sig_out;
   sample_t             mod_out;
   logic [num_keys-1:0] held_keys;

   // reference model state
   sample_t             ref_rom [0:63];
   logic [31:0]         m_acc;
   logic [31:0]         m_inc;
   wave_sel_e           m_wave;
   mod_sel_e            m_msel;
   sample_t             m_sin;
   sample_t             m_cos;
   sample_t             m_saw;
   sample_t             m_squ;
   sample_t             m_sig;
   sample_t             m_mod;
   int                  m_tick;
   logic [4:0]          m_lfsr;
   logic                m_ack;
   logic [num_keys-1:0] m_keys;
   logic                check_on;
   int                  err_cnt;
   int                  test_cnt;
   int                  fail_cnt;

   dds_lab_top u_dds_lab_top (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .cfg_req        (cfg_req),
      .cfg_cmd        (cfg_cmd),
      .kbd_event      (kbd_event),
      .cfg_ack        (cfg_ack),
      .sig_out        (sig_out),
      .mod_out        (mod_out),
      .held_keys      (held_keys)
   );

   bind dds_lab_top dds_lab_checker u_dds_lab_checker (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .cfg_req        (cfg_req),
      .cfg_ack        (cfg_ack),
      .mod_sel        (dds_ctrl.mod_sel),
      .mod_out        (mod_out)
   );

   always #clk_half CLK_25MHZ = ~CLK_25MHZ;

   task automatic expect_val(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp)
      begin
         $display("Error: %s got %h expected %h at %0t", name, got, exp, $time);
         err_cnt++;
      end
   endtask

   task automatic finish_test(input string name, input int err_mark);
      test_cnt++;
      if (err_cnt == err_mark)
         $display("%s: ok", name);
      else
      begin
         fail_cnt++;
         $display("%s: failed with %0d errors", name, err_cnt - err_mark);
      end
   endtask

   task automatic wait_cycles(input int n);
      repeat (n) @(posedge CLK_25MHZ);
   endtask

   // host side of the four-phase handshake
   task automatic write_cfg(input cfg_addr_e addr, input cfg_word_u word);
      int n;
      int hold;
      @(posedge CLK_25MHZ);
      #drive_dly;
      cfg_cmd.addr = addr;
      cfg_cmd.word = word;
      cfg_req      = 1'b1;
      n = 0;
      while (!cfg_ack && n < 4)
      begin
         @(posedge CLK_25MHZ);
         #drive_dly;
         n++;
      end
      if (!cfg_ack)
      begin
         $display("cfg_ack did not rise within 4 cycles of cfg_req at %0t", $time);
         err_cnt++;
      end
      else if (n != 1)
      begin
         $display("cfg_ack rose %0d cycles after cfg_req instead of 1", n);
         err_cnt++;
      end
      // host may keep req up a few cycles after ack
      hold = $urandom_range(2, 0);
      while (cfg_ack && hold > 0)
      begin
         @(posedge CLK_25MHZ);
         #drive_dly;
         hold--;
         if (!cfg_ack)
         begin
            $display("cfg_ack fell while cfg_req was still high at %0t", $time);
            err_cnt++;
         end
      end
      cfg_req = 1'b0;
      n = 0;
      while (cfg_ack && n < 4)
      begin
         @(posedge CLK_25MHZ);
         #drive_dly;
         n++;
      end
      if (cfg_ack)
      begin
         $display("cfg_ack stayed high 4 cycles after cfg_req fell at %0t", $time);
         err_cnt++;
      end
      else if (n != 1)
      begin
         $display("cfg_ack fell %0d cycles after cfg_req instead of 1", n);
         err_cnt++;
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // reference model, one step per rising edge
   //////////////////////////////////////////////////////////////////////

   always @(posedge CLK_25MHZ)
   begin
      logic [5:0] idx;
      logic [5:0] cidx;
      sample_t    w;
      if (reset_from_key)
      begin
         m_acc  = '0;
         m_inc  = '0;
         m_wave = SINE;
         m_msel = ASK;
         m_sin  = '0;
         m_cos  = '0;
         m_saw  = '0;
         m_squ  = '0;
         m_sig  = '0;
         m_mod  = '0;
         m_tick = 0;
         m_lfsr = 5'b00001;
         m_ack  = 1'b0;
         m_keys = '0;
      end
      else
      begin
         // output stage uses last cycle's samples and selectors
         case (m_wave)
            SINE:    w = m_sin;
            COS:     w = m_cos;
            SAW:     w = m_saw;
            default: w = m_squ;
         endcase
         m_sig = w;
         case (m_msel)
            ASK:       m_mod = m_lfsr[0] ? ask_level : '0;
            BPSK:      m_mod = m_lfsr[0] ? ~w + 12'd1 : w;
            LFSR_SHOW: m_mod = m_lfsr[0] ? lfsr_mark : '0;
            default:   m_mod = '0;
         endcase
         idx   = m_acc[31:26];
         cidx  = idx + 6'd16;
         m_sin = ref_rom[idx];
         m_cos = ref_rom[cidx];
         m_saw = m_acc[31:20];
         m_squ = m_acc[31] ? square_lo : square_hi;
         m_acc = m_acc + m_inc;
         if (m_tick == lfsr_tick_cycles - 1)
         begin
            m_tick = 0;
            m_lfsr = {m_lfsr[3:0], m_lfsr[4] ^ m_lfsr[2]};
         end
         else
            m_tick = m_tick + 1;
         if (cfg_req && !m_ack)
         begin
            m_ack = 1'b1;
            if (cfg_cmd.addr == CFG_PHASE_INC)
               m_inc = cfg_cmd.word.freq;
            else
            begin
               m_wave = cfg_cmd.word.sel.wave_sel;
               m_msel = cfg_cmd.word.sel.mod_sel;
            end
         end
         else if (!cfg_req)
            m_ack = 1'b0;
         if (kbd_event.valid && int'(kbd_event.code) < num_keys)
            m_keys[kbd_event.code] = !kbd_event.brk;  // break clears
      end
   end

   // outputs are settled by the falling edge
   always @(negedge CLK_25MHZ)
   begin
      if (check_on)
      begin
         expect_val("cfg_ack", 32'(cfg_ack), 32'(m_ack));
         expect_val("sig_out", 32'(sig_out), 32'(m_sig));
         expect_val("mod_out", 32'(mod_out), 32'(m_mod));
         expect_val("held_keys", 32'(held_keys), 32'(m_keys));
      end
   end

   //////////////////////////////////////////////////////////////////////
   // watchdog and test sequence
   //////////////////////////////////////////////////////////////////////

   initial
   begin
      #(wd_cycles * 2 * clk_half);
      $display("watchdog expired after %0d cycles, the run did not finish", wd_cycles);
      $display("TEST FAILED");
      $finish;
   end

   initial
   begin
      logic [31:0] r;
      cfg_word_u   w;
      int          err_mark;
      void'($urandom(32'h35ed));
      $readmemh("rtl/sine_table.mem", ref_rom);
      CLK_25MHZ      = 1'b0;
      reset_from_key = 1'b1;
      cfg_req        = 1'b0;
      cfg_cmd        = '0;
      kbd_event      = '0;
      check_on       = 1'b0;
      err_cnt        = 0;
      test_cnt       = 0;
      fail_cnt       = 0;
      repeat (3) @(posedge CLK_25MHZ);
      #drive_dly;
      reset_from_key = 1'b0;

      err_mark = err_cnt;
      expect_val("cfg_ack", 32'(cfg_ack), 32'd0);
      expect_val("sig_out", 32'(sig_out), 32'd0);
      expect_val("mod_out", 32'(mod_out), 32'd0);
      expect_val("held_keys", 32'(held_keys), 32'd0);
      check_on = 1'b1;
      finish_test("reset state", err_mark);

      err_mark = err_cnt;
      for (int i = 0; i < num_writes; i++)
      begin
         w.freq = $urandom;
         write_cfg((i % 2 == 0) ? CFG_PHASE_INC : CFG_SELECT, w);
      end
      finish_test("config handshake", err_mark);

      err_mark = err_cnt;
      for (int ws = 0; ws < 4; ws++)
      begin
         w.freq = $urandom >> 6;  // at least 64 samples per period
         write_cfg(CFG_PHASE_INC, w);
         w.sel.rsvd     = '0;
         w.sel.mod_sel  = NONE;
         w.sel.wave_sel = wave_sel_e'(ws[1:0]);
         write_cfg(CFG_SELECT, w);
         wait_cycles(wave_cycles);
      end
      finish_test("waveforms", err_mark);

      err_mark = err_cnt;
      for (int ms = 0; ms < 4; ms++)
      begin
         r = $urandom;
         w.sel.rsvd     = '0;
         w.sel.mod_sel  = mod_sel_e'(ms[1:0]);
         w.sel.wave_sel = wave_sel_e'(r[1:0]);
         write_cfg(CFG_SELECT, w);
         wait_cycles(mod_cycles);
      end
      finish_test("modulation", err_mark);

      err_mark = err_cnt;
      repeat (num_events)
      begin
         @(posedge CLK_25MHZ);
         #drive_dly;
         r = $urandom;
         kbd_event.valid = r[0] | r[1];
         kbd_event.brk   = r[2];
         kbd_event.code  = r[8:4];  // upper half hits unused codes
      end
      @(posedge CLK_25MHZ);
      #drive_dly;
      kbd_event.valid = 1'b0;
      wait_cycles(2);
      finish_test("key tracking", err_mark);

      $display("tests run %0d, failed %0d, errors %0d", test_cnt, fail_cnt, err_cnt);
      if (err_cnt == 0)
         $display("TEST PASSED");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule
